// ==== hdl/rename_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared sizes and types for the integer register rename stage.
// Sizes are fixed here. The rename stage assumes phys_regs > arch_regs
// and a two-lane group. Checkpoint slots are addressed by a 2-bit index,
// so at most four checkpoints can be used.
////////////////////////////////////////////////////////////////////////////

package rename_pkg;

  // Register file sizes
  localparam int arch_regs    = 32;
  localparam int phys_regs    = 64;
  localparam int rename_width = 2;

  localparam int arch_idx_w   = $clog2(arch_regs);
  localparam int phys_idx_w   = $clog2(phys_regs);
  localparam int free_count_w = $clog2(phys_regs + 1);

  typedef logic [arch_idx_w-1:0]   arch_idx_t;
  typedef logic [phys_idx_w-1:0]   phys_idx_t;
  // Holds 0 up to phys_regs inclusive
  typedef logic [free_count_w-1:0] free_count_t;

  ////////////////////////////////////////////////////////////////////////////
  // Per-lane request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      valid;
    logic      dest_valid;
    arch_idx_t dest;
    arch_idx_t src1;
    arch_idx_t src2;
  } rename_req_t;

  typedef struct packed {
    logic      valid;
    logic      dest_valid;
    phys_idx_t phys_dest;
    phys_idx_t phys_src1;
    phys_idx_t phys_src2;
    // Mapping replaced by this lane, freed at commit
    phys_idx_t old_dest;
  } rename_rsp_t;

  // Commit-side release of one physical register
  typedef struct packed {
    logic      valid;
    phys_idx_t phys;
  } release_t;

  ////////////////////////////////////////////////////////////////////////////
  // Branch checkpoint control
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ckpt_none    = 2'd0,
    ckpt_save    = 2'd1,
    ckpt_restore = 2'd2
  } ckpt_op_e;

  typedef struct packed {
    ckpt_op_e   op;
    logic [1:0] slot;
  } ckpt_cmd_t;

endpackage

// ==== hdl/free_list.sv ====
////////////////////////////////////////////////////////////////////////////
// Physical register free list as a busy bitmap with a free count.
// free_head gives the lowest free registers from current state only, so
// releases become visible one cycle later. Register 0 is never handed out.
// The slot in ckpt_in must be below checkpoint_count. A restore ignores
// alloc_mask; releases are applied on top of the restored state.
////////////////////////////////////////////////////////////////////////////

module free_list #(
  parameter int checkpoint_count = 4
) (
  input  logic                                                 clock,
  input  logic                                                 reset,
  input  logic                [rename_pkg::rename_width-1:0]   alloc_mask,
  input  rename_pkg::release_t [rename_pkg::rename_width-1:0]  release_in,
  input  rename_pkg::ckpt_cmd_t                                ckpt_in,
  output rename_pkg::phys_idx_t [rename_pkg::rename_width-1:0] free_head,
  output logic                                                 rename_ready
);

  // Bitmap and count kept together so checkpoints copy both at once
  typedef struct packed {
    logic [rename_pkg::phys_regs-1:0] busy;
    rename_pkg::free_count_t          count;
  } free_state_t;

  // Registers 0..arch_regs-1 hold the identity mapping after reset
  localparam free_state_t reset_state = '{
    busy:  {{(rename_pkg::phys_regs - rename_pkg::arch_regs){1'b0}},
            {rename_pkg::arch_regs{1'b1}}},
    count: rename_pkg::free_count_t'(rename_pkg::phys_regs - rename_pkg::arch_regs)
  };

  free_state_t                      state;
  free_state_t                      state_next;
  free_state_t                      ckpt_state [checkpoint_count];
  free_state_t                      ckpt_next  [checkpoint_count];
  logic [rename_pkg::phys_regs-1:0] alloc_bits;
  rename_pkg::free_count_t          alloc_count;

  // Frees every released register that is still busy in the given state
  function automatic free_state_t release_regs(
    input free_state_t                                          current,
    input rename_pkg::release_t [rename_pkg::rename_width-1:0] rel
  );
    free_state_t result;
    result = current;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      if (rel[i].valid && (rel[i].phys != '0) && result.busy[rel[i].phys]) begin
        result.busy[rel[i].phys] = 1'b0;
        result.count             = result.count + 1'b1;
      end
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Lowest free registers
  ////////////////////////////////////////////////////////////////////////////

  // Priority scan from register 1 upward
  always_comb begin
    int unsigned found;
    found = 0;
    for (int h = 0; h < rename_pkg::rename_width; h++) begin
      free_head[h] = '0;
    end
    for (int i = 1; i < rename_pkg::phys_regs; i++) begin
      if (!state.busy[i] && (found < rename_pkg::rename_width)) begin
        free_head[found] = rename_pkg::phys_idx_t'(i);
        found            = found + 1;
      end
    end
  end

  // Only depends on the count held at the start of the cycle
  assign rename_ready =
    (state.count >= rename_pkg::free_count_t'(rename_pkg::rename_width));

  ////////////////////////////////////////////////////////////////////////////
  // Allocation and next state
  ////////////////////////////////////////////////////////////////////////////

  // Allocating lanes take head entries in lane order
  always_comb begin
    alloc_bits  = '0;
    alloc_count = '0;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      if (alloc_mask[i]) begin
        alloc_bits[free_head[alloc_count]] = 1'b1;
        alloc_count                        = alloc_count + 1'b1;
      end
    end
  end

  always_comb begin
    free_state_t base;
    if (ckpt_in.op == rename_pkg::ckpt_restore) begin
      base = ckpt_state[ckpt_in.slot];
    end else begin
      base.busy  = state.busy | alloc_bits;
      base.count = state.count - alloc_count;
    end
    state_next = release_regs(base, release_in);
  end

  // Stored checkpoints see every release so nothing leaks on restore
  always_comb begin
    for (int k = 0; k < checkpoint_count; k++) begin
      ckpt_next[k] = release_regs(ckpt_state[k], release_in);
      if ((ckpt_in.op == rename_pkg::ckpt_save) && (ckpt_in.slot == k)) begin
        // Save captures the state after this cycle's group and releases
        ckpt_next[k] = state_next;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= reset_state;
      for (int k = 0; k < checkpoint_count; k++) begin
        ckpt_state[k] <= reset_state;
      end
    end else begin
      state <= state_next;
      for (int k = 0; k < checkpoint_count; k++) begin
        ckpt_state[k] <= ckpt_next[k];
      end
    end
  end

endmodule

// ==== hdl/map_table.sv ====
////////////////////////////////////////////////////////////////////////////
// Architectural to physical map with branch checkpoints.
// Decides group acceptance and the allocation mask; lane 0 is older than
// lane 1 and younger lanes see older lanes' new mappings in the same group.
// Responses are registered, one cycle after acceptance. Architectural
// register x0 is never remapped, so its sources always read register 0.
////////////////////////////////////////////////////////////////////////////

module map_table #(
  parameter int checkpoint_count = 4
) (
  input  logic                                                   clock,
  input  logic                                                   reset,
  input  rename_pkg::rename_req_t [rename_pkg::rename_width-1:0] rename_in,
  input  rename_pkg::phys_idx_t   [rename_pkg::rename_width-1:0] free_head,
  input  logic                                                   rename_ready,
  input  rename_pkg::ckpt_cmd_t                                  ckpt_in,
  output logic                    [rename_pkg::rename_width-1:0] alloc_mask,
  output rename_pkg::rename_rsp_t [rename_pkg::rename_width-1:0] rename_out
);

  rename_pkg::phys_idx_t map_state [rename_pkg::arch_regs];
  rename_pkg::phys_idx_t map_next  [rename_pkg::arch_regs];
  rename_pkg::phys_idx_t ckpt_map  [checkpoint_count][rename_pkg::arch_regs];

  rename_pkg::rename_rsp_t [rename_pkg::rename_width-1:0] rsp_next;
  logic                                                   any_valid;
  logic                                                   accept;

  ////////////////////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////////////////////

  // Restore discards the group in the same cycle
  always_comb begin
    any_valid = 1'b0;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      any_valid = any_valid | rename_in[i].valid;
    end
    accept = rename_ready && (ckpt_in.op != rename_pkg::ckpt_restore) && any_valid;
  end

  // A lane allocates when it writes a register other than x0
  always_comb begin
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      alloc_mask[i] = accept && rename_in[i].valid && rename_in[i].dest_valid &&
                      (rename_in[i].dest != '0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup with in-group bypass
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    int unsigned head;
    head = 0;
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      rsp_next[i]            = '0;
      rsp_next[i].valid      = accept && rename_in[i].valid;
      rsp_next[i].dest_valid = alloc_mask[i];
      rsp_next[i].phys_src1  = map_state[rename_in[i].src1];
      rsp_next[i].phys_src2  = map_state[rename_in[i].src2];
      if (alloc_mask[i]) begin
        rsp_next[i].phys_dest = free_head[head];
        rsp_next[i].old_dest  = map_state[rename_in[i].dest];
        head                  = head + 1;
      end
      // Older lanes in ascending order, so the youngest older writer wins
      for (int j = 0; j < i; j++) begin
        if (alloc_mask[j]) begin
          if (rename_in[j].dest == rename_in[i].src1) begin
            rsp_next[i].phys_src1 = rsp_next[j].phys_dest;
          end
          if (rename_in[j].dest == rename_in[i].src2) begin
            rsp_next[i].phys_src2 = rsp_next[j].phys_dest;
          end
          if (alloc_mask[i] && (rename_in[j].dest == rename_in[i].dest)) begin
            rsp_next[i].old_dest = rsp_next[j].phys_dest;
          end
        end
      end
    end
  end

  // Registered responses
  always_ff @(posedge clock) begin
    rename_out <= rsp_next;
    if (reset) begin
      for (int i = 0; i < rename_pkg::rename_width; i++) begin
        rename_out[i].valid      <= 1'b0;
        rename_out[i].dest_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Map update and checkpoints
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    map_next = map_state;
    if (ckpt_in.op == rename_pkg::ckpt_restore) begin
      map_next = ckpt_map[ckpt_in.slot];
    end else begin
      // Lane order so a younger lane overwrites the same register
      for (int i = 0; i < rename_pkg::rename_width; i++) begin
        if (alloc_mask[i]) begin
          map_next[rename_in[i].dest] = rsp_next[i].phys_dest;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rename_pkg::arch_regs; r++) begin
        map_state[r] <= rename_pkg::phys_idx_t'(r);
      end
    end else begin
      map_state <= map_next;
    end
  end

  // Save takes the map including this cycle's group
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int k = 0; k < checkpoint_count; k++) begin
        for (int r = 0; r < rename_pkg::arch_regs; r++) begin
          ckpt_map[k][r] <= rename_pkg::phys_idx_t'(r);
        end
      end
    end else if (ckpt_in.op == rename_pkg::ckpt_save) begin
      ckpt_map[ckpt_in.slot] <= map_next;
    end
  end

endmodule

// ==== hdl/rename_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Register rename stage, two micro-ops per cycle.
// A group is taken when rename_ready is high, no restore is requested and
// a lane is valid; a refused group must be held by the source. Results
// appear on rename_out one cycle after acceptance. checkpoint_count may
// be 1 to 4, and the front end picks checkpoint slots below that value.
////////////////////////////////////////////////////////////////////////////

module rename_unit #(
  parameter int checkpoint_count = 4
) (
  input  logic                                                   clock,
  input  logic                                                   reset,

  // Decode side
  input  rename_pkg::rename_req_t [rename_pkg::rename_width-1:0] rename_in,
  output logic                                                   rename_ready,
  output rename_pkg::rename_rsp_t [rename_pkg::rename_width-1:0] rename_out,

  // Commit side
  input  rename_pkg::release_t    [rename_pkg::rename_width-1:0] release_in,

  // Branch checkpoint control
  input  rename_pkg::ckpt_cmd_t                                  ckpt_in
);

  // Lowest free registers, taken by allocating lanes in order
  rename_pkg::phys_idx_t [rename_pkg::rename_width-1:0] free_head;
  // Lanes of an accepted group that allocate
  logic                  [rename_pkg::rename_width-1:0] alloc_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Map table
  ////////////////////////////////////////////////////////////////////////////

  map_table #(
    .checkpoint_count (checkpoint_count)
  ) u_map_table (
    .clock        (clock),
    .reset        (reset),
    .rename_in    (rename_in),
    .free_head    (free_head),
    .rename_ready (rename_ready),
    .ckpt_in      (ckpt_in),
    .alloc_mask   (alloc_mask),
    .rename_out   (rename_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Free list
  ////////////////////////////////////////////////////////////////////////////

  // Also drives rename_ready from its registered free count
  free_list #(
    .checkpoint_count (checkpoint_count)
  ) u_free_list (
    .clock        (clock),
    .reset        (reset),
    .alloc_mask   (alloc_mask),
    .release_in   (release_in),
    .ckpt_in      (ckpt_in),
    .free_head    (free_head),
    .rename_ready (rename_ready)
  );

endmodule

// ==== tests/rename_tb_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// Directed tests for the rename stage, included into the testbench module.
// Tests run in order and the later ones rely on the state left behind,
// except where a test resets the DUT first.
////////////////////////////////////////////////////////////////////////////

function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state >> 16;
endfunction

function automatic rename_pkg::rename_req_t make_req(input bit dest_valid, input int dest,
                                                     input int src1, input int src2);
  rename_pkg::rename_req_t r;
  r.valid      = 1'b1;
  r.dest_valid = dest_valid;
  r.dest       = rename_pkg::arch_idx_t'(dest);
  r.src1       = rename_pkg::arch_idx_t'(src1);
  r.src2       = rename_pkg::arch_idx_t'(src2);
  return r;
endfunction

function automatic rename_pkg::release_t make_release(input int phys);
  rename_pkg::release_t r;
  r.valid = 1'b1;
  r.phys  = rename_pkg::phys_idx_t'(phys);
  return r;
endfunction

function automatic rename_pkg::ckpt_cmd_t make_ckpt(input rename_pkg::ckpt_op_e op,
                                                    input int slot);
  rename_pkg::ckpt_cmd_t c;
  c.op   = op;
  c.slot = 2'(slot);
  return c;
endfunction

task automatic begin_test(input string name);
  test_name   = name;
  test_errors = errors;
endtask

task automatic end_test();
  $display("test %s finished with %0d errors", test_name, errors - test_errors);
endtask

task automatic wait_ready();
  int cycles;
  cycles = 0;
  while (!rename_ready) begin
    if (cycles == resp_timeout) report_hang("rename_ready going high");
    @(negedge clock);
    cycles++;
  end
endtask

task automatic test_identity();
  req_group_t req;
  rsp_group_t got;
  rsp_group_t exp_rsp;
  begin_test("identity");
  req[0] = make_req(1'b1, 5, 1, 2);
  req[1] = make_req(1'b1, 7, 3, 0);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  check_value("lane 0 phys_dest", 32, got[0].phys_dest);
  check_value("lane 1 phys_dest", 33, got[1].phys_dest);
  check_value("lane 0 old_dest", 5, got[0].old_dest);
  check_value("lane 1 old_dest", 7, got[1].old_dest);
  check_value("lane 0 phys_src2", 2, got[0].phys_src2);
  check_value("lane 1 phys_src1", 3, got[1].phys_src1);
  end_test();
endtask

// Lane 1 reads and rewrites the register lane 0 just renamed
task automatic test_bypass();
  req_group_t req;
  rsp_group_t got;
  rsp_group_t exp_rsp;
  begin_test("bypass");
  req[0] = make_req(1'b1, 9, 1, 5);
  req[1] = make_req(1'b1, 9, 9, 7);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  check_value("lane 0 phys_src2", 32, got[0].phys_src2);
  check_value("lane 1 phys_src1", 34, got[1].phys_src1);
  check_value("lane 1 old_dest", 34, got[1].old_dest);
  check_value("lane 1 phys_dest", 35, got[1].phys_dest);
  end_test();
endtask

task automatic test_exhaustion();
  req_group_t req;
  rel_group_t rel;
  rsp_group_t got;
  rsp_group_t exp_rsp;
  begin_test("exhaustion");
  reset_dut();
  // First group retires the identity registers 1 and 2
  req[0] = make_req(1'b1, 1, 3, 4);
  req[1] = make_req(1'b1, 2, 1, 2);
  for (int g = 0; g < 16; g++) begin
    drive_group(req, no_release, no_ckpt, got, exp_rsp);
  end
  check_value("rename_ready after 32 allocations", 0, rename_ready);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  check_value("lane 0 valid of refused group", 0, got[0].valid);
  rel[0] = make_release(2);
  rel[1] = make_release(1);
  drive_group(no_group, rel, no_ckpt, got, exp_rsp);
  wait_ready();
  req[0] = make_req(1'b1, 3, 0, 0);
  req[1] = make_req(1'b1, 4, 0, 0);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  check_value("lane 0 phys_dest", 1, got[0].phys_dest);
  check_value("lane 1 phys_dest", 2, got[1].phys_dest);
  end_test();
endtask

task automatic test_checkpoint();
  req_group_t req;
  rel_group_t rel;
  rsp_group_t got;
  rsp_group_t exp_rsp;
  begin_test("checkpoint");
  reset_dut();
  req[0] = make_req(1'b1, 3, 1, 2);
  req[1] = make_req(1'b1, 4, 3, 0);
  drive_group(req, no_release, make_ckpt(rename_pkg::ckpt_save, 1), got, exp_rsp);
  // Wrong-path work after the branch
  req[0] = make_req(1'b1, 3, 4, 0);
  req[1] = make_req(1'b1, 6, 3, 0);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  rel[0] = make_release(4);
  rel[1] = '0;
  drive_group(no_group, rel, no_ckpt, got, exp_rsp);
  drive_group(req, no_release, make_ckpt(rename_pkg::ckpt_restore, 1), got, exp_rsp);
  check_value("lane 0 valid during restore", 0, got[0].valid);
  req[0] = make_req(1'b1, 7, 3, 6);
  req[1] = make_req(1'b1, 8, 4, 0);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  check_value("lane 0 phys_src1", 32, got[0].phys_src1);
  check_value("lane 0 phys_src2", 6, got[0].phys_src2);
  check_value("lane 1 phys_src1", 33, got[1].phys_src1);
  check_value("lane 0 phys_dest", 4, got[0].phys_dest);
  check_value("lane 1 phys_dest", 34, got[1].phys_dest);
  end_test();
endtask

task automatic test_zero_reg();
  req_group_t req;
  rsp_group_t got;
  rsp_group_t exp_rsp;
  begin_test("zero_reg");
  req[0] = make_req(1'b1, 0, 0, 0);
  req[1] = make_req(1'b1, 10, 0, 3);
  drive_group(req, no_release, no_ckpt, got, exp_rsp);
  check_value("lane 0 dest_valid", 0, got[0].dest_valid);
  check_value("lane 0 phys_src1", 0, got[0].phys_src1);
  check_value("lane 1 phys_src1", 0, got[1].phys_src1);
  check_value("lane 1 phys_src2", 32, got[1].phys_src2);
  check_value("lane 1 phys_dest", 35, got[1].phys_dest);
  end_test();
endtask

// Replaced mappings are released later, in order
task automatic test_random();
  req_group_t  req;
  rel_group_t  rel;
  rsp_group_t  got;
  rsp_group_t  exp_rsp;
  int unsigned pending [$];
  bit          dest_valid;
  int          dest;
  int          src1;
  int          src2;
  begin_test("random");
  for (int n = 0; n < 200; n++) begin
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      dest_valid         = (lcg_next() % 4) != 0;
      dest               = lcg_next() % rename_pkg::arch_regs;
      src1               = lcg_next() % rename_pkg::arch_regs;
      src2               = lcg_next() % rename_pkg::arch_regs;
      req[i]             = make_req(dest_valid, dest, src1, src2);
      req[i].valid       = (lcg_next() % 8) != 0;
      rel[i]             = '0;
      if ((pending.size() > 0) && ((lcg_next() % 4) != 0)) begin
        rel[i] = make_release(pending.pop_front());
      end
    end
    drive_group(req, rel, no_ckpt, got, exp_rsp);
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      if (exp_rsp[i].dest_valid) pending.push_back(exp_rsp[i].old_dest);
    end
  end
  end_test();
endtask

// ==== tests/rename_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the rename stage, with a shadow model of map and free set.
// Each transaction drives one cycle of inputs, then one idle cycle, and
// compares the registered response with the model. Checkpoint slots stay
// below the DUT's checkpoint_count of 4.
////////////////////////////////////////////////////////////////////////////

module rename_tb;

  typedef rename_pkg::rename_req_t [rename_pkg::rename_width-1:0] req_group_t;
  typedef rename_pkg::rename_rsp_t [rename_pkg::rename_width-1:0] rsp_group_t;
  typedef rename_pkg::release_t    [rename_pkg::rename_width-1:0] rel_group_t;

  localparam int ckpt_slots   = 4;
  localparam int resp_timeout = 16;

  localparam req_group_t            no_group   = '0;
  localparam rel_group_t            no_release = '0;
  localparam rename_pkg::ckpt_cmd_t no_ckpt    = '0;

  logic                  clock;
  logic                  reset;
  req_group_t            rename_in;
  logic                  rename_ready;
  rsp_group_t            rename_out;
  rel_group_t            release_in;
  rename_pkg::ckpt_cmd_t ckpt_in;

  string       test_name;
  int          checks;
  int          errors;
  int          test_errors;
  bit          hung;
  int unsigned lcg_state;

  // Shadow model of map, free set and checkpoints
  int map_m        [rename_pkg::arch_regs];
  bit busy_m       [rename_pkg::phys_regs];
  int count_m;
  int ckpt_map_m   [ckpt_slots][rename_pkg::arch_regs];
  bit ckpt_busy_m  [ckpt_slots][rename_pkg::phys_regs];
  int ckpt_count_m [ckpt_slots];

  always #20 clock = ~clock;

  rename_unit #(
    .checkpoint_count (ckpt_slots)
  ) dut (
    .clock        (clock),
    .reset        (reset),
    .rename_in    (rename_in),
    .rename_ready (rename_ready),
    .rename_out   (rename_out),
    .release_in   (release_in),
    .ckpt_in      (ckpt_in)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void model_reset();
    for (int r = 0; r < rename_pkg::phys_regs; r++) begin
      busy_m[r] = (r < rename_pkg::arch_regs);
    end
    for (int r = 0; r < rename_pkg::arch_regs; r++) begin
      map_m[r] = r;
    end
    count_m = rename_pkg::phys_regs - rename_pkg::arch_regs;
    for (int k = 0; k < ckpt_slots; k++) begin
      ckpt_map_m[k]   = map_m;
      ckpt_busy_m[k]  = busy_m;
      ckpt_count_m[k] = count_m;
    end
  endfunction

  function automatic int lowest_free();
    for (int r = 1; r < rename_pkg::phys_regs; r++) begin
      if (!busy_m[r]) return r;
    end
    return 0;
  endfunction

  // A release frees the register now and in every stored checkpoint
  function automatic void model_release(input int p);
    if (p == 0) return;
    if (busy_m[p]) begin
      busy_m[p] = 1'b0;
      count_m++;
    end
    for (int k = 0; k < ckpt_slots; k++) begin
      if (ckpt_busy_m[k][p]) begin
        ckpt_busy_m[k][p] = 1'b0;
        ckpt_count_m[k]++;
      end
    end
  endfunction

  // Lanes in program order, so lane 1 sees lane 0's new mapping
  function automatic void model_step(input req_group_t req, input rel_group_t rel,
                                     input rename_pkg::ckpt_cmd_t ckpt,
                                     output rsp_group_t exp_rsp, output bit accepted);
    int p;
    exp_rsp  = '0;
    accepted = (count_m >= rename_pkg::rename_width) &&
               (ckpt.op != rename_pkg::ckpt_restore) && (req[0].valid || req[1].valid);
    if (ckpt.op == rename_pkg::ckpt_restore) begin
      map_m   = ckpt_map_m[ckpt.slot];
      busy_m  = ckpt_busy_m[ckpt.slot];
      count_m = ckpt_count_m[ckpt.slot];
    end else if (accepted) begin
      for (int i = 0; i < rename_pkg::rename_width; i++) begin
        if (req[i].valid) begin
          exp_rsp[i].valid     = 1'b1;
          exp_rsp[i].phys_src1 = rename_pkg::phys_idx_t'(map_m[req[i].src1]);
          exp_rsp[i].phys_src2 = rename_pkg::phys_idx_t'(map_m[req[i].src2]);
          if (req[i].dest_valid && (req[i].dest != 0)) begin
            p                     = lowest_free();
            exp_rsp[i].dest_valid = 1'b1;
            exp_rsp[i].phys_dest  = rename_pkg::phys_idx_t'(p);
            exp_rsp[i].old_dest   = rename_pkg::phys_idx_t'(map_m[req[i].dest]);
            map_m[req[i].dest]    = p;
            busy_m[p]             = 1'b1;
            count_m--;
          end
        end
      end
    end
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      if (rel[i].valid) model_release(rel[i].phys);
    end
    if (ckpt.op == rename_pkg::ckpt_save) begin
      ckpt_map_m[ckpt.slot]   = map_m;
      ckpt_busy_m[ckpt.slot]  = busy_m;
      ckpt_count_m[ckpt.slot] = count_m;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking and driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string field, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("error %s: %s expected %0d actual %0d", test_name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic report_hang(input string what);
    $display("timeout in test %s: %s never happened", test_name, what);
    hung = 1'b1;
    forever @(posedge clock);
  endtask

  task automatic wait_response(input bit accepted);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (accepted && !(rename_out[0].valid || rename_out[1].valid)) begin
      if (cycles == resp_timeout) report_hang("a rename response");
      @(negedge clock);
      cycles++;
    end
  endtask

  task automatic compare_group(input rsp_group_t exp_rsp, input rsp_group_t got);
    for (int i = 0; i < rename_pkg::rename_width; i++) begin
      check_value($sformatf("lane %0d valid", i), exp_rsp[i].valid, got[i].valid);
      check_value($sformatf("lane %0d dest_valid", i), exp_rsp[i].dest_valid,
                  got[i].dest_valid);
      if (exp_rsp[i].valid) begin
        check_value($sformatf("lane %0d phys_src1", i), exp_rsp[i].phys_src1, got[i].phys_src1);
        check_value($sformatf("lane %0d phys_src2", i), exp_rsp[i].phys_src2, got[i].phys_src2);
      end
      if (exp_rsp[i].dest_valid) begin
        check_value($sformatf("lane %0d phys_dest", i), exp_rsp[i].phys_dest, got[i].phys_dest);
        check_value($sformatf("lane %0d old_dest", i), exp_rsp[i].old_dest, got[i].old_dest);
      end
    end
  endtask

  // One cycle of stimulus, an idle cycle, then the response check
  task automatic drive_group(input req_group_t req, input rel_group_t rel,
                             input rename_pkg::ckpt_cmd_t ckpt,
                             output rsp_group_t got, output rsp_group_t exp_rsp);
    bit accepted;
    @(posedge clock);
    rename_in  <= req;
    release_in <= rel;
    ckpt_in    <= ckpt;
    model_step(req, rel, ckpt, exp_rsp, accepted);
    @(posedge clock);
    rename_in  <= '0;
    release_in <= '0;
    ckpt_in    <= '0;
    wait_response(accepted);
    got = rename_out;
    compare_group(exp_rsp, got);
    check_value("rename_ready", int'(count_m >= rename_pkg::rename_width), rename_ready);
  endtask

  task automatic reset_dut();
    @(posedge clock);
    reset      <= 1'b1;
    rename_in  <= '0;
    release_in <= '0;
    ckpt_in    <= '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    model_reset();
    @(negedge clock);
    check_value("rename_ready after reset", 1, rename_ready);
    check_value("lane 0 valid after reset", 0, rename_out[0].valid);
    check_value("lane 1 valid after reset", 0, rename_out[1].valid);
  endtask

  `include "rename_tb_tasks.svh"

  initial begin
    clock      = 1'b0;
    reset      = 1'b1;
    rename_in  = '0;
    release_in = '0;
    ckpt_in    = '0;
    test_name  = "reset";
    checks     = 0;
    errors     = 0;
    hung       = 1'b0;
    lcg_state  = 87449;
    fork
      begin
        reset_dut();
        test_identity();
        test_bypass();
        test_exhaustion();
        test_checkpoint();
        test_zero_reg();
        test_random();
      end
      wait (hung);
    join_any
    disable fork;
    $display("checks %0d, errors %0d", checks, errors);
    if ((errors == 0) && !hung) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+tests
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/rename_unit.sv
tests/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  # Package first, then the stage from the leaves up
  - hdl/rename_pkg.sv
  - hdl/free_list.sv
  - hdl/map_table.sv
  - hdl/rename_unit.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/rename_tb.sv
